// File: dataPath.f
src/isaPkg.sv
src/busPkg.sv
src/gprCtrlIf.sv
src/gprFile.sv
src/busMux.sv
src/alu.sv
src/irDecode.sv
src/conFf.sv
src/dataPath.sv
bench/tbClock.sv
bench/tbDataPath.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f dataPath.f --top-module tbDataPath \
	-o simDataPath \
	&& ./obj_dir/simDataPath | tee /dev/stderr | grep -q "^TB PASSED$" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: bench/tbDataPath.sv
module tbDataPath;
	import busPkg::*;
	import isaPkg::*;

	localparam int aluRounds = 4;
	// Reset, transfers, ALU rounds, constant, branch tests and idle edges
	localparam int scriptCycles = 16 + 14 + (aluRounds * 13 + 1) * 6 + 12 + 4 * 8 + 4;
	localparam int cycleLimit = 2 * scriptCycles;

	logic clock;
	logic arstN;
	logic irIn, pcIn, ryIn, zIn, marIn, mdrIn, hiIn, loIn, outportIn, strobe;
	logic hiOut, loOut, zHiOut, zLoOut, pcOut, mdrOut, inportOut, cOut;
	logic memRead, incPc, gra, grb, grc, rIn, rOut, baOut, conIn, conFfBit;
	logic [4:0] opcode;
	logic [addrWidth-1:0] marToChip, modelMar;
	word_t memDataIn, memDataOut, externalIn, externalOut;

	// Predicted bus and hidden register contents
	word_t expBus, inportVal, irVal, modelOut, modelMdr;
	word_t gprVal [regCount];
	logic modelCon;
	logic [31:0] lfsrState;
	int cycleCount = 0;
	int outErrs = 0;
	int marErrs = 0;
	int mdrErrs = 0;
	int conErrs = 0;
	aluOp_t opList [13] = '{opAdd, opSub, opAnd, opOr, opShr, opShra, opShl,
		opRor, opRol, opMul, opDiv, opNeg, opNot};

	tbClock clockGen (.clock(clock));

	dataPath dut (.*);

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = {lfsrState[30:0],
				lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	// Expected Z for RY = a and bus = b
	function automatic logic [63:0] aluModel(input aluOp_t op, input word_t a, input word_t b);
		int sh;
		word_t low;
		sh = int'(b[4:0]);
		case (op)
			opSub: low = a - b;
			opAnd: low = a & b;
			opOr: low = a | b;
			opShr: low = a >> sh;
			opShra: low = $signed(a) >>> sh;
			opShl: low = a << sh;
			opRor: low = (a >> sh) | (a << (32 - sh));
			opRol: low = (a << sh) | (a >> (32 - sh));
			opNeg: low = -b;
			opNot: low = ~b;
			opMul: return {{32{a[31]}}, a} * {{32{b[31]}}, b};
			opDiv: return (b == '0) ? '0
				: {word_t'($signed(a) % $signed(b)), word_t'($signed(a) / $signed(b))};
			default: low = a + b;
		endcase
		return {32'h0, low};
	endfunction

	function automatic logic condModel(input logic [1:0] c2, input word_t v);
		case (c2)
			2'b00: return v == '0;
			2'b01: return v != '0;
			2'b10: return !v[31] && v != '0;
			default: return v[31];
		endcase
	endfunction

	task automatic clearControls();
		{irIn, pcIn, ryIn, zIn, marIn, mdrIn, hiIn, loIn, outportIn, strobe} = '0;
		{hiOut, loOut, zHiOut, zLoOut, pcOut, mdrOut, inportOut, cOut} = '0;
		{memRead, incPc, gra, grb, grc, rIn, rOut, baOut, conIn} = '0;
		opcode = '0;
	endtask

	// New controls go out on the falling edge
	task automatic startCycle();
		@(negedge clock);
		clearControls();
	endtask

	task automatic captureInput(input word_t v);
		startCycle();
		externalIn = v;
		strobe = 1'b1;
		inportVal = v;
	endtask

	// Memory word into MDR, then over the bus into IR
	task automatic loadIrFromMemory(input word_t v);
		startCycle();
		memDataIn = v;
		memRead = 1'b1;
		mdrIn = 1'b1;
		startCycle();
		mdrOut = 1'b1;
		irIn = 1'b1;
		expBus = v;
		irVal = v;
	endtask

	task automatic inportToRa();
		startCycle();
		inportOut = 1'b1;
		gra = 1'b1;
		rIn = 1'b1;
		expBus = inportVal;
		gprVal[irVal[raHi:raLo]] = inportVal;
	endtask

	task automatic raToOutport(input logic ba);
		startCycle();
		gra = 1'b1;
		rOut = 1'b1;
		baOut = ba;
		outportIn = 1'b1;
		expBus = (ba && irVal[raHi:raLo] == 0) ? '0 : gprVal[irVal[raHi:raLo]];
	endtask

	// Input port through HI, LO, PC and MDR to the output port
	task automatic passThroughSpecials(input word_t v);
		captureInput(v);
		startCycle();
		inportOut = 1'b1;
		hiIn = 1'b1;
		expBus = v;
		startCycle();
		hiOut = 1'b1;
		loIn = 1'b1;
		startCycle();
		loOut = 1'b1;
		pcIn = 1'b1;
		// MDR from the bus with memRead low
		startCycle();
		pcOut = 1'b1;
		mdrIn = 1'b1;
		startCycle();
		mdrOut = 1'b1;
		outportIn = 1'b1;
	endtask

	// RY from a, Z from bus value b, then both halves of Z to the port
	task automatic aluStep(input aluOp_t op, input word_t a, input word_t b, input logic inc);
		logic [63:0] z;
		z = inc ? {32'h0, b + 32'h1} : aluModel(op, a, b);
		captureInput(a);
		startCycle();
		inportOut = 1'b1;
		ryIn = 1'b1;
		expBus = a;
		captureInput(b);
		startCycle();
		inportOut = 1'b1;
		zIn = 1'b1;
		opcode = op;
		incPc = inc;
		expBus = b;
		startCycle();
		zLoOut = 1'b1;
		outportIn = 1'b1;
		expBus = z[31:0];
		startCycle();
		zHiOut = 1'b1;
		outportIn = 1'b1;
		expBus = z[63:32];
	endtask

	task automatic conditionStep(input word_t v);
		captureInput(v);
		startCycle();
		inportOut = 1'b1;
		conIn = 1'b1;
		expBus = v;
	endtask

	// Expected output registers loaded by the same strobes as the DUT
	always @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			modelOut <= '0;
			modelMar <= '0;
			modelMdr <= '0;
			modelCon <= 1'b0;
		end else begin
			if (outportIn) modelOut <= expBus;
			if (marIn) modelMar <= expBus[addrWidth-1:0];
			if (mdrIn) modelMdr <= memRead ? memDataIn : expBus;
			if (conIn) modelCon <= condModel(irVal[c2Hi:c2Lo], expBus);
		end
	end

	outportCheck: assert property (@(posedge clock) disable iff (!arstN)
		externalOut == modelOut) else begin
		outErrs++;
		$display("Fail at %0t: externalOut %h, expected %h", $time,
			$sampled(externalOut), $sampled(modelOut));
	end

	marCheck: assert property (@(posedge clock) disable iff (!arstN)
		marToChip == modelMar) else begin
		marErrs++;
		$display("Fail at %0t: marToChip %h, expected %h", $time,
			$sampled(marToChip), $sampled(modelMar));
	end

	mdrCheck: assert property (@(posedge clock) disable iff (!arstN)
		memDataOut == modelMdr) else begin
		mdrErrs++;
		$display("Fail at %0t: memDataOut %h, expected %h", $time,
			$sampled(memDataOut), $sampled(modelMdr));
	end

	conCheck: assert property (@(posedge clock) disable iff (!arstN)
		conFfBit == modelCon) else begin
		conErrs++;
		$display("Fail at %0t: conFfBit %b, expected %b", $time,
			$sampled(conFfBit), $sampled(modelCon));
	end

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == cycleLimit) begin
			$display("Timeout: the test script did not end within %0d cycles", cycleLimit);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		word_t irWord;
		word_t a;
		word_t b;
		int start;
		lfsrState = 32'hc2d9_384b;
		arstN = 1'b0;
		externalIn = '0;
		memDataIn = '0;
		expBus = '0;
		inportVal = '0;
		irVal = '0;
		for (int i = 0; i < regCount; i++) begin
			gprVal[i] = '0;
		end
		clearControls();
		repeat (16) @(negedge clock);
		arstN = 1'b1;
		// Outputs keep their reset values over these idle edges
		startCycle();
		startCycle();

		// Input port into the ra register and out again
		loadIrFromMemory(randomBits(32));
		captureInput(randomBits(32));
		inportToRa();
		raToOutport(1'b0);
		passThroughSpecials(randomBits(32));

		// Zero bus operand in the first round covers divide by zero
		for (int round = 0; round < aluRounds; round++) begin
			start = int'(randomBits(4));
			for (int k = 0; k < 13; k++) begin
				a = randomBits(32);
				b = (round == 0) ? '0 : randomBits(32);
				aluStep(opList[(start + k) % 13], a, b, 1'b0);
			end
		end
		a = randomBits(32);
		b = randomBits(32);
		aluStep(opAdd, a, b, 1'b1);

		// Negative constant onto MAR and the output port
		irWord = randomBits(32);
		irWord[constHi] = 1'b1;
		loadIrFromMemory(irWord);
		startCycle();
		cOut = 1'b1;
		marIn = 1'b1;
		outportIn = 1'b1;
		expBus = {{13{irWord[constHi]}}, irWord[constHi:constLo]};
		// ra cleared to reach R0
		irWord[raHi:raLo] = '0;
		loadIrFromMemory(irWord);
		captureInput(randomBits(32) | 32'h1);
		inportToRa();
		raToOutport(1'b1);
		raToOutport(1'b0);

		for (int c = 0; c < 4; c++) begin
			irWord = randomBits(32);
			irWord[c2Hi:c2Lo] = c[1:0];
			loadIrFromMemory(irWord);
			a = randomBits(32);
			conditionStep('0);
			conditionStep({1'b0, a[30:1], 1'b1});
			conditionStep({1'b1, a[30:0]});
		end
		startCycle();
		startCycle();

		$display("Errors: externalOut %0d, marToChip %0d, memDataOut %0d, conFfBit %0d",
			outErrs, marErrs, mdrErrs, conErrs);
		if (outErrs + marErrs + mdrErrs + conErrs == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: bench/tbClock.sv
module tbClock (
	output logic clock
);
	// Period of 8 time units
	localparam int halfPeriod = 4;

	initial begin
		clock = 1'b0;
	end

	always begin
		#halfPeriod clock = ~clock;
	end

endmodule

// File: src/dataPath.sv
module dataPath (
	input logic clock,
	input logic arstN,
	// Register load strobes
	input logic irIn, pcIn, ryIn, zIn, marIn, mdrIn, hiIn, loIn, outportIn, strobe,
	// Bus source strobes
	input logic hiOut, loOut, zHiOut, zLoOut, pcOut, mdrOut, inportOut, cOut,
	// Memory side
	input logic memRead,
	input busPkg::word_t memDataIn,
	output busPkg::word_t memDataOut,
	output logic [busPkg::addrWidth-1:0] marToChip,
	// I/O ports
	input busPkg::word_t externalIn,
	output busPkg::word_t externalOut,
	// From the control unit
	input logic [4:0] opcode,
	input logic incPc,
	input logic gra, grb, grc, rIn, rOut, baOut, conIn,
	output logic conFfBit
);
	import busPkg::*;
	import isaPkg::*;

	word_t bus;
	word_t ir, pc, ry, zHi, zLo, hi, lo, mar, mdr, inport, outport;
	word_t cSext;
	logic [2*wordWidth-1:0] aluResult;

	gprCtrlIf regCtrl ();

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			ir <= '0;
			pc <= '0;
			ry <= '0;
			zHi <= '0;
			zLo <= '0;
			hi <= '0;
			lo <= '0;
			mar <= '0;
			mdr <= '0;
			inport <= '0;
			outport <= '0;
		end else begin
			if (irIn) ir <= bus;
			if (pcIn) pc <= bus;
			if (ryIn) ry <= bus;
			if (hiIn) hi <= bus;
			if (loIn) lo <= bus;
			if (marIn) mar <= bus;
			// Z captures both halves of the ALU result
			if (zIn) begin
				zHi <= aluResult[2*wordWidth-1:wordWidth];
				zLo <= aluResult[wordWidth-1:0];
			end
			// memRead picks memory over the bus
			if (mdrIn) mdr <= memRead ? memDataIn : bus;
			if (strobe) inport <= externalIn;
			if (outportIn) outport <= bus;
		end
	end

	assign memDataOut = mdr;
	assign marToChip = mar[addrWidth-1:0];
	assign externalOut = outport;

	irDecode irDec (
		.ir(ir), .gra(gra), .grb(grb), .grc(grc), .rIn(rIn), .rOut(rOut),
		.ctrl(regCtrl), .cSext(cSext)
	);

	gprFile regs (
		.clock(clock), .arstN(arstN), .bus(bus), .baOut(baOut), .ctrl(regCtrl)
	);

	busMux mux (
		.clock(clock), .arstN(arstN), .ctrl(regCtrl),
		.hiOut(hiOut), .loOut(loOut), .zHiOut(zHiOut), .zLoOut(zLoOut),
		.pcOut(pcOut), .mdrOut(mdrOut), .inportOut(inportOut), .cOut(cOut),
		.hi(hi), .lo(lo), .zHi(zHi), .zLo(zLo),
		.pc(pc), .mdr(mdr), .inport(inport), .cSext(cSext),
		.bus(bus)
	);

	alu aluUnit (
		.a(ry), .b(bus), .op(aluOp_t'(opcode)), .incPc(incPc), .result(aluResult)
	);

	conFf branchFf (
		.clock(clock), .arstN(arstN), .ir(ir), .bus(bus), .conIn(conIn),
		.conFfBit(conFfBit)
	);

endmodule

// File: src/conFf.sv
module conFf (
	input logic clock,
	input logic arstN,
	input busPkg::word_t ir,
	input busPkg::word_t bus,
	input logic conIn,
	output logic conFfBit
);
	import busPkg::*;
	import isaPkg::*;

	cond_t c2;
	logic isZero;
	logic condMet;

	assign c2 = cond_t'(ir[c2Hi:c2Lo]);
	assign isZero = (bus == '0);

	always_comb begin
		case (c2)
			condZero: condMet = isZero;
			condNonZero: condMet = !isZero;
			// Strictly greater than zero
			condPositive: condMet = !bus[wordWidth-1] && !isZero;
			default: condMet = bus[wordWidth-1];
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			conFfBit <= 1'b0;
		end else if (conIn) begin
			conFfBit <= condMet;
		end
	end

endmodule

// File: src/irDecode.sv
module irDecode (
	input busPkg::word_t ir,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic rIn,
	input logic rOut,
	gprCtrlIf.decoder ctrl,
	output busPkg::word_t cSext
);
	import busPkg::*;
	import isaPkg::*;

	logic [raHi-raLo:0] regSel;
	logic [regCount-1:0] decoded;

	// Only one of gra, grb, grc is expected per cycle
	assign regSel = ({(raHi-raLo+1){gra}} & ir[raHi:raLo])
		| ({(rbHi-rbLo+1){grb}} & ir[rbHi:rbLo])
		| ({(rcHi-rcLo+1){grc}} & ir[rcHi:rcLo]);

	always_comb begin
		decoded = '0;
		decoded[regSel] = 1'b1;
	end

	assign ctrl.rIn = decoded & {regCount{rIn}};
	assign ctrl.rOut = decoded & {regCount{rOut}};

	// 19-bit constant field to a full word
	assign cSext = {{(wordWidth-constHi-1){ir[constHi]}}, ir[constHi:constLo]};

endmodule

// File: src/alu.sv
module alu (
	input busPkg::word_t a,
	input busPkg::word_t b,
	input isaPkg::aluOp_t op,
	input logic incPc,
	output logic [2*busPkg::wordWidth-1:0] result
);
	import busPkg::*;
	import isaPkg::*;

	logic signed [wordWidth-1:0] aS;
	logic signed [wordWidth-1:0] bS;
	logic signed [2*wordWidth-1:0] product;
	logic [4:0] shamt;
	logic [2*wordWidth-1:0] rorWide;
	logic [2*wordWidth-1:0] rolWide;
	word_t quotient;
	word_t remainder;

	assign aS = a;
	assign bS = b;
	assign shamt = b[4:0];

	// Full signed product
	assign product = aS * bS;

	// Rotates via a doubled copy of the operand
	assign rorWide = {a, a} >> shamt;
	assign rolWide = {a, a} << shamt;

	always_comb begin
		if (b == '0) begin
			quotient = '0;
			remainder = '0;
		end else begin
			quotient = aS / bS;
			remainder = aS % bS;
		end
	end

	always_comb begin
		result = '0;
		if (incPc) begin
			result = {{wordWidth{1'b0}}, b + 1'b1};
		end else begin
			case (op)
				opSub: result = {{wordWidth{1'b0}}, a - b};
				opAnd: result = {{wordWidth{1'b0}}, a & b};
				opOr: result = {{wordWidth{1'b0}}, a | b};
				opShr: result = {{wordWidth{1'b0}}, a >> shamt};
				opShra: result = {{wordWidth{1'b0}}, aS >>> shamt};
				opShl: result = {{wordWidth{1'b0}}, a << shamt};
				opRor: result = {{wordWidth{1'b0}}, rorWide[wordWidth-1:0]};
				opRol: result = {{wordWidth{1'b0}}, rolWide[2*wordWidth-1:wordWidth]};
				opMul: result = product;
				// Remainder high, quotient low
				opDiv: result = {remainder, quotient};
				// Unary ops take their operand from the bus
				opNeg: result = {{wordWidth{1'b0}}, -bS};
				opNot: result = {{wordWidth{1'b0}}, ~b};
				// Loads and immediates use the adder too
				default: result = {{wordWidth{1'b0}}, a + b};
			endcase
		end
	end

endmodule

// File: src/busMux.sv
module busMux (
	input logic clock,
	input logic arstN,
	gprCtrlIf.mux ctrl,
	input logic hiOut,
	input logic loOut,
	input logic zHiOut,
	input logic zLoOut,
	input logic pcOut,
	input logic mdrOut,
	input logic inportOut,
	input logic cOut,
	input busPkg::word_t hi,
	input busPkg::word_t lo,
	input busPkg::word_t zHi,
	input busPkg::word_t zLo,
	input busPkg::word_t pc,
	input busPkg::word_t mdr,
	input busPkg::word_t inport,
	input busPkg::word_t cSext,
	output busPkg::word_t bus
);
	import busPkg::*;

	// Registers in the low sixteen slots, special sources above
	logic [regCount+7:0] outSel;
	word_t [regCount+7:0] srcWords;

	assign outSel = {cOut, inportOut, mdrOut, pcOut, zLoOut, zHiOut, loOut, hiOut, ctrl.rOut};
	assign srcWords = {cSext, inport, mdr, pc, zLo, zHi, lo, hi, ctrl.regs};

	// Bus stays zero when nothing drives it
	always_comb begin
		bus = '0;
		for (int i = 0; i < $size(outSel); i++) begin
			bus = bus | (srcWords[i] & {wordWidth{outSel[i]}});
		end
	end

	// Decoder strobes and control strobes together pick at most one source
	singleDriver: assert property (
		@(posedge clock) disable iff (!arstN)
		$onehot0(outSel)
	) else $error("busMux: more than one bus source enabled");

endmodule

// File: src/gprFile.sv
module gprFile (
	input logic clock,
	input logic arstN,
	input busPkg::word_t bus,
	input logic baOut,
	gprCtrlIf.file ctrl
);
	import busPkg::*;

	regArray_t regFile;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			regFile <= '0;
		end else begin
			for (int i = 0; i < regCount; i++) begin
				if (ctrl.rIn[i]) begin
					regFile[i] <= bus;
				end
			end
		end
	end

	// R0 reads as zero for base-address mode
	assign ctrl.regs[0] = baOut ? '0 : regFile[0];
	assign ctrl.regs[regCount-1:1] = regFile[regCount-1:1];

	// Decoder must never select two destinations at once
	rInOneHot: assert property (
		@(posedge clock) disable iff (!arstN)
		$onehot0(ctrl.rIn)
	) else $error("gprFile: more than one register write enable high");

endmodule

// File: src/gprCtrlIf.sv
interface gprCtrlIf;
	import busPkg::*;

	// One-hot write enables
	logic [regCount-1:0] rIn;
	// One-hot read enables
	logic [regCount-1:0] rOut;
	// Register values as seen by the bus
	regArray_t regs;

	modport decoder (output rIn, output rOut);
	modport file (input rIn, output regs);
	modport mux (input rOut, input regs);

endinterface

// File: src/busPkg.sv
package busPkg;

	// Bus and register width
	localparam int wordWidth = 32;

	// General registers R0..R15
	localparam int regCount = 16;

	// Address lines to the memory chip
	localparam int addrWidth = 9;

	typedef logic [wordWidth-1:0] word_t;

	// R0 sits at index 0
	typedef logic [regCount-1:0][wordWidth-1:0] regArray_t;

endpackage

// File: src/isaPkg.sv
package isaPkg;

	// IR field positions
	localparam int opHi = 31;
	localparam int opLo = 27;
	localparam int raHi = 26;
	localparam int raLo = 23;
	localparam int rbHi = 22;
	localparam int rbLo = 19;
	localparam int rcHi = 18;
	localparam int rcLo = 15;
	localparam int constHi = 18;
	localparam int constLo = 0;
	localparam int c2Hi = 20;
	localparam int c2Lo = 19;

	// ALU function codes, same values as the instruction opcodes
	typedef enum logic [4:0] {
		opAdd = 5'd3,
		opSub = 5'd4,
		opAnd = 5'd5,
		opOr = 5'd6,
		opRor = 5'd7,
		opRol = 5'd8,
		opShr = 5'd9,
		opShra = 5'd10,
		opShl = 5'd11,
		opDiv = 5'd15,
		opMul = 5'd16,
		opNeg = 5'd17,
		opNot = 5'd18
	} aluOp_t;

	// Branch conditions in C2
	typedef enum logic [1:0] {
		condZero = 2'b00,
		condNonZero = 2'b01,
		condPositive = 2'b10,
		condNegative = 2'b11
	} cond_t;

endpackage
